//--- exu_pkg.sv
// execute stage encodings; import into any block that decodes ALU, branch, load or control fields
`default_nettype none

package exu_pkg;

  localparam int XLEN = 64;

  // field widths and number of keys per lookup
  localparam int ALU_OP_W  = 5;
  localparam int B_SEL_W   = 2;
  localparam int BRANCH_W  = 3;
  localparam int MEM_OP_W  = 3;
  localparam int EX_CTR_W  = 4;
  localparam int NR_ALU_OP = 19;
  localparam int NR_B_SEL  = 3;
  localparam int NR_BRANCH = 7;
  localparam int NR_MEM_OP = 7;

  typedef logic [XLEN-1:0] xlen_t;

  // sequential pc step, also the constant operand
  localparam xlen_t PC_STEP = xlen_t'(4);

  typedef enum logic [ALU_OP_W-1:0] {
    ALU_ADD      = 5'b00000,
    ALU_SUB      = 5'b00001,
    ALU_SLT      = 5'b00010,
    ALU_SLTU     = 5'b00011,
    ALU_XOR      = 5'b00100,
    ALU_AND      = 5'b00101,
    ALU_OR       = 5'b00110,
    ALU_SLL      = 5'b00111,
    ALU_SRL      = 5'b01000,
    ALU_SRA      = 5'b01001,
    ALU_MUL      = 5'b01010,
    ALU_DIV      = 5'b01011,
    ALU_DIVU     = 5'b01100,
    ALU_REM      = 5'b01101,
    ALU_REMU     = 5'b01110,
    ALU_COPY_IMM = 5'b01111,
    ALU_MULH     = 5'b11001,
    ALU_MULHSU   = 5'b11010,
    ALU_MULHU    = 5'b11011
  } alu_op_e;

  typedef enum logic [B_SEL_W-1:0] {
    B_SEL_RS2  = 2'b00,
    B_SEL_IMM  = 2'b01,
    B_SEL_FOUR = 2'b10
  } alu_b_sel_e;

  // blt/bge cover the unsigned forms too, alu_op picks the compare
  typedef enum logic [BRANCH_W-1:0] {
    BR_NONE = 3'b000,
    BR_JAL  = 3'b001,
    BR_JALR = 3'b010,
    BR_BEQ  = 3'b100,
    BR_BNE  = 3'b101,
    BR_BLT  = 3'b110,
    BR_BGE  = 3'b111
  } branch_e;

  typedef enum logic [MEM_OP_W-1:0] {
    MEM_LB  = 3'b000,
    MEM_LBU = 3'b001,
    MEM_LH  = 3'b010,
    MEM_LHU = 3'b011,
    MEM_LW  = 3'b100,
    MEM_LWU = 3'b101,
    MEM_LD  = 3'b110
  } mem_op_e;

  // any code other than csr write and ebreak means no action
  typedef enum logic [EX_CTR_W-1:0] {
    EX_CSR_WR = 4'b0000,
    EX_EBREAK = 4'b1110,
    EX_NONE   = 4'b1111
  } ex_ctr_e;

endpackage

`default_nettype wire

//--- exu_bus_pkg.sv
// request and response records of the execute stage, shared by the RTL and the testbench
`default_nettype none

package exu_bus_pkg;

  typedef struct packed {
    exu_pkg::xlen_t      rs1;
    exu_pkg::xlen_t      rs2;
    exu_pkg::xlen_t      imm;
    exu_pkg::xlen_t      pc;
    exu_pkg::xlen_t      rdata;
    logic                alu_a_pc;
    exu_pkg::alu_b_sel_e alu_b_sel;
    exu_pkg::alu_op_e    alu_op;
    logic                word_cut;
    exu_pkg::branch_e    branch;
    exu_pkg::mem_op_e    mem_op;
    logic                mem_to_reg;
    logic                sel_csr;
    exu_pkg::ex_ctr_e    ex_ctr;
    logic                invalid_inst;
  } ex_req_t;

  typedef struct packed {
    exu_pkg::xlen_t alu_result;
    exu_pkg::xlen_t next_pc;
    exu_pkg::xlen_t gpr_wdata;
    exu_pkg::xlen_t csr_wdata;
  } ex_rsp_t;

  // first ALU operand, also the value written to a CSR
  function automatic exu_pkg::xlen_t alu_src_a(ex_req_t req);
    exu_pkg::xlen_t rs1_cut;
    rs1_cut = req.word_cut ? {{(exu_pkg::XLEN-32){1'b0}}, req.rs1[31:0]} : req.rs1;
    return req.alu_a_pc ? req.pc : rs1_cut;
  endfunction

endpackage

`default_nettype wire

//--- key_mux.sv
// keyed lookup mux; pass flat {key, value} pairs and get the value matching i_key, else zero
`timescale 1ns/1ps
`default_nettype none

module key_mux #(
  parameter int  NR_KEY  = 2,
  parameter int  KEY_LEN = 1,
  parameter type T       = logic
) (
  input  logic [KEY_LEN-1:0]                      i_key,
  input  logic [NR_KEY*(KEY_LEN+$bits(T))-1:0]    i_lut,
  output T                                        o_out
);

  // pair i sits at bit i*(KEY_LEN+$bits(T)), value below key
  always_comb begin
    o_out = '0;
    for (int i = 0; i < NR_KEY; i++) begin
      if (i_lut[i*(KEY_LEN+$bits(T))+$bits(T) +: KEY_LEN] == i_key) begin
        o_out = T'(i_lut[i*(KEY_LEN+$bits(T)) +: $bits(T)]);
      end
    end
  end

endmodule

`default_nettype wire

//--- exu_alu.sv
// execute ALU; combinational, give it the request and take the result plus zero/less flags
`timescale 1ns/1ps
`default_nettype none

module exu_alu (
  input  exu_bus_pkg::ex_req_t         i_req,
  output logic [exu_pkg::XLEN-1:0]     o_result,
  output logic                         o_zero,
  output logic                         o_less
);
  import exu_pkg::*;
  import exu_bus_pkg::*;

  function automatic xlen_t sext_w(xlen_t v);
    return {{(XLEN-32){v[31]}}, v[31:0]};
  endfunction

  xlen_t src2, imm_cut, src_a, src_b;
  xlen_t diff, raw_result;
  logic  carry, ovf, less_s, less_u;
  logic [5:0] shamt;
  xlen_t sll_res, srl_res, sra_res;
  logic [2*XLEN-1:0] prod_ss, prod_su, prod_uu;
  xlen_t div_a, div_b, div_b_safe, divu_b_safe;
  logic  div_zero, div_ovf, divu_zero;
  xlen_t quot_s, rem_s, quot_u, rem_u;

  // word ops see zero-extended 32-bit operands
  assign src2    = i_req.word_cut ? {{(XLEN-32){1'b0}}, i_req.rs2[31:0]} : i_req.rs2;
  assign imm_cut = i_req.word_cut ? {{(XLEN-32){1'b0}}, i_req.imm[31:0]} : i_req.imm;
  assign src_a   = alu_src_a(i_req);

  key_mux #(.NR_KEY(NR_B_SEL), .KEY_LEN(B_SEL_W), .T(xlen_t)) u_src_b_mux (
    .i_key (i_req.alu_b_sel),
    .i_lut ({B_SEL_RS2, src2, B_SEL_IMM, imm_cut, B_SEL_FOUR, PC_STEP}),
    .o_out (src_b)
  );

  // a - b drives both compare flags
  assign {carry, diff} = {1'b0, src_a} + {1'b0, ~src_b} + {{XLEN{1'b0}}, 1'b1};
  assign ovf    = (src_a[XLEN-1] ^ src_b[XLEN-1]) & (diff[XLEN-1] ^ src_a[XLEN-1]);
  assign less_s = diff[XLEN-1] ^ ovf;
  assign less_u = ~carry;
  assign o_zero = ~|diff;
  assign o_less = (i_req.alu_op == ALU_SLTU) ? less_u : less_s;

  assign shamt   = i_req.word_cut ? {1'b0, src_b[4:0]} : src_b[5:0];
  assign sll_res = src_a << shamt;
  assign srl_res = src_a >> shamt;
  assign sra_res = $signed(i_req.word_cut ? sext_w(src_a) : src_a) >>> shamt;

  assign prod_ss = $signed(src_a) * $signed(src_b);
  assign prod_su = $signed(src_a) * $signed({1'b0, src_b});
  assign prod_uu = src_a * src_b;

  // signed div/rem on sign-extended words for W forms
  assign div_a      = i_req.word_cut ? sext_w(src_a) : src_a;
  assign div_b      = i_req.word_cut ? sext_w(src_b) : src_b;
  assign div_zero   = (div_b == '0);
  assign div_ovf    = (div_a == {1'b1, {(XLEN-1){1'b0}}}) && (div_b == '1);
  assign div_b_safe = (div_zero || div_ovf) ? xlen_t'(1) : div_b;
  assign quot_s     = div_zero ? '1 : xlen_t'($signed(div_a) / $signed(div_b_safe));
  assign rem_s      = div_zero ? div_a :
                      div_ovf  ? '0 : xlen_t'($signed(div_a) % $signed(div_b_safe));

  assign divu_zero   = (src_b == '0);
  assign divu_b_safe = divu_zero ? xlen_t'(1) : src_b;
  assign quot_u      = divu_zero ? '1 : src_a / divu_b_safe;
  assign rem_u       = divu_zero ? src_a : src_a % divu_b_safe;

  key_mux #(.NR_KEY(NR_ALU_OP), .KEY_LEN(ALU_OP_W), .T(xlen_t)) u_result_mux (
    .i_key (i_req.alu_op),
    .i_lut ({
      ALU_COPY_IMM, i_req.imm,
      ALU_ADD,      xlen_t'(src_a + src_b),
      ALU_SUB,      diff,
      ALU_SLT,      {{(XLEN-1){1'b0}}, less_s},
      ALU_SLTU,     {{(XLEN-1){1'b0}}, less_u},
      ALU_XOR,      xlen_t'(src_a ^ src_b),
      ALU_AND,      xlen_t'(src_a & src_b),
      ALU_OR,       xlen_t'(src_a | src_b),
      ALU_SLL,      sll_res,
      ALU_SRL,      srl_res,
      ALU_SRA,      sra_res,
      ALU_MUL,      prod_uu[XLEN-1:0],
      ALU_MULH,     prod_ss[2*XLEN-1:XLEN],
      ALU_MULHSU,   prod_su[2*XLEN-1:XLEN],
      ALU_MULHU,    prod_uu[2*XLEN-1:XLEN],
      ALU_DIV,      quot_s,
      ALU_DIVU,     quot_u,
      ALU_REM,      rem_s,
      ALU_REMU,     rem_u
    }),
    .o_out (raw_result)
  );

  // W results are sign-extended from bit 31
  assign o_result = i_req.word_cut ? sext_w(raw_result) : raw_result;

endmodule

`default_nettype wire

//--- exu_branch.sv
// next pc logic; combinational, feed it the branch kind and ALU flags to get the following pc
`timescale 1ns/1ps
`default_nettype none

module exu_branch (
  input  exu_pkg::branch_e          i_branch,
  input  logic [exu_pkg::XLEN-1:0]  i_pc,
  input  logic [exu_pkg::XLEN-1:0]  i_rs1,
  input  logic [exu_pkg::XLEN-1:0]  i_imm,
  input  logic                      i_zero,
  input  logic                      i_less,
  output logic [exu_pkg::XLEN-1:0]  o_next_pc
);
  import exu_pkg::*;

  logic taken;
  logic base_rs1;

  key_mux #(.NR_KEY(NR_BRANCH), .KEY_LEN(BRANCH_W), .T(logic)) u_taken_mux (
    .i_key (i_branch),
    .i_lut ({
      BR_NONE, 1'b0,
      BR_JAL,  1'b1,
      BR_JALR, 1'b1,
      BR_BEQ,  i_zero,
      BR_BNE,  ~i_zero,
      BR_BLT,  i_less,
      BR_BGE,  ~i_less
    }),
    .o_out (taken)
  );

  // only jalr jumps relative to rs1
  key_mux #(.NR_KEY(NR_BRANCH), .KEY_LEN(BRANCH_W), .T(logic)) u_base_mux (
    .i_key (i_branch),
    .i_lut ({
      BR_NONE, 1'b0,
      BR_JAL,  1'b0,
      BR_JALR, 1'b1,
      BR_BEQ,  1'b0,
      BR_BNE,  1'b0,
      BR_BLT,  1'b0,
      BR_BGE,  1'b0
    }),
    .o_out (base_rs1)
  );

  assign o_next_pc = (base_rs1 ? i_rs1 : i_pc) + (taken ? i_imm : PC_STEP);

endmodule

`default_nettype wire

//--- exu_wb_sel.sv
// register write value select; combinational, extends load data and picks load, rs2 or ALU result
`timescale 1ns/1ps
`default_nettype none

module exu_wb_sel (
  input  logic [exu_pkg::XLEN-1:0]  i_rdata,
  input  exu_pkg::mem_op_e          i_mem_op,
  input  logic                      i_mem_to_reg,
  input  logic                      i_sel_csr,
  input  logic [exu_pkg::XLEN-1:0]  i_rs2,
  input  logic [exu_pkg::XLEN-1:0]  i_alu_result,
  output logic [exu_pkg::XLEN-1:0]  o_gpr_wdata
);
  import exu_pkg::*;

  xlen_t load_ext;

  key_mux #(.NR_KEY(NR_MEM_OP), .KEY_LEN(MEM_OP_W), .T(xlen_t)) u_load_mux (
    .i_key (i_mem_op),
    .i_lut ({
      MEM_LB,  {{(XLEN-8){i_rdata[7]}}, i_rdata[7:0]},
      MEM_LBU, {{(XLEN-8){1'b0}}, i_rdata[7:0]},
      MEM_LH,  {{(XLEN-16){i_rdata[15]}}, i_rdata[15:0]},
      MEM_LHU, {{(XLEN-16){1'b0}}, i_rdata[15:0]},
      MEM_LW,  {{(XLEN-32){i_rdata[31]}}, i_rdata[31:0]},
      MEM_LWU, {{(XLEN-32){1'b0}}, i_rdata[31:0]},
      MEM_LD,  i_rdata
    }),
    .o_out (load_ext)
  );

  // csr reads land in rs2 upstream
  assign o_gpr_wdata = i_mem_to_reg ? load_ext : (i_sel_csr ? i_rs2 : i_alu_result);

endmodule

`default_nettype wire

//--- exu_core.sv
// combinational execute unit; maps one request to its response plus ebreak/invalid pulses
`timescale 1ns/1ps
`default_nettype none

module exu_core (
  input  exu_bus_pkg::ex_req_t  i_req,
  output exu_bus_pkg::ex_rsp_t  o_rsp,
  output logic                  o_ebreak,
  output logic                  o_invalid
);
  import exu_pkg::*;
  import exu_bus_pkg::*;

  xlen_t alu_result;
  xlen_t next_pc;
  xlen_t gpr_wdata;
  xlen_t csr_wdata;
  logic  zero;
  logic  less;

  exu_alu u_alu (
    .i_req    (i_req),
    .o_result (alu_result),
    .o_zero   (zero),
    .o_less   (less)
  );

  exu_branch u_branch (
    .i_branch  (i_req.branch),
    .i_pc      (i_req.pc),
    .i_rs1     (i_req.rs1),
    .i_imm     (i_req.imm),
    .i_zero    (zero),
    .i_less    (less),
    .o_next_pc (next_pc)
  );

  exu_wb_sel u_wb_sel (
    .i_rdata      (i_req.rdata),
    .i_mem_op     (i_req.mem_op),
    .i_mem_to_reg (i_req.mem_to_reg),
    .i_sel_csr    (i_req.sel_csr),
    .i_rs2        (i_req.rs2),
    .i_alu_result (alu_result),
    .o_gpr_wdata  (gpr_wdata)
  );

  // csr gets operand a, zero for anything but a csr write
  assign csr_wdata = (i_req.ex_ctr == EX_CSR_WR) ? alu_src_a(i_req) : '0;

  assign o_rsp = '{
    alu_result: alu_result,
    next_pc:    next_pc,
    gpr_wdata:  gpr_wdata,
    csr_wdata:  csr_wdata
  };

  assign o_ebreak  = (i_req.ex_ctr == EX_EBREAK);
  assign o_invalid = i_req.invalid_inst;

endmodule

`default_nettype wire

//--- exu_top.sv
// execute stage top; strobe a request on i_valid and read its response one cycle later
`timescale 1ns/1ps
`default_nettype none

module exu_top (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_valid,
  input  exu_bus_pkg::ex_req_t  i_req,
  output logic                  o_valid,
  output exu_bus_pkg::ex_rsp_t  o_rsp,
  output logic                  o_halt,
  output logic                  o_abort
);
  import exu_bus_pkg::*;

  ex_rsp_t core_rsp;
  logic    core_ebreak;
  logic    core_invalid;

  exu_core u_core (
    .i_req     (i_req),
    .o_rsp     (core_rsp),
    .o_ebreak  (core_ebreak),
    .o_invalid (core_invalid)
  );

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
      o_rsp   <= '0;
      o_halt  <= 1'b0;
      o_abort <= 1'b0;
    end else begin
      o_valid <= i_valid;
      if (i_valid) begin
        o_rsp   <= core_rsp;
        // sticky until reset
        o_halt  <= o_halt | core_ebreak;
        o_abort <= o_abort | core_invalid;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
// testbench clock and power-on reset; 10 ns period, reset held low for the first 10 rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (10) @(posedge o_clk);
    o_rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

//--- exu_tb.sv
// directed testbench for the execute stage; drives exu_top and checks every response one cycle later
`timescale 1ns/1ps
`default_nettype none

module exu_tb;
  import exu_pkg::*;
  import exu_bus_pkg::*;

  // tests need about 400 cycles
  localparam int TIMEOUT_CYCLES = 2000;
  localparam xlen_t MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

  logic    clk;
  logic    gen_rst_n;
  logic    tb_rst_n;
  logic    valid;
  ex_req_t req;
  logic    rsp_valid;
  ex_rsp_t rsp;
  logic    halt;
  logic    abort;
  int      cycles = 0;
  int      seed;

  alu_op_e op_list [19] = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_AND, ALU_OR,
                            ALU_SLL, ALU_SRL, ALU_SRA, ALU_MUL, ALU_MULH, ALU_MULHSU,
                            ALU_MULHU, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU, ALU_COPY_IMM};
  branch_e br_list [7] = '{BR_NONE, BR_JAL, BR_JALR, BR_BEQ, BR_BNE, BR_BLT, BR_BGE};

  tb_clk_gen u_clk_gen (
    .o_clk   (clk),
    .o_rst_n (gen_rst_n)
  );

  exu_top uut (
    .i_clk   (clk),
    .i_rst_n (gen_rst_n & tb_rst_n),
    .i_valid (valid),
    .i_req   (req),
    .o_valid (rsp_valid),
    .o_rsp   (rsp),
    .o_halt  (halt),
    .o_abort (abort)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("FAIL: see errors above");
      $fatal(1, "timeout");
    end
  end

  function automatic xlen_t zext_word(xlen_t v);
    return {32'h0, v[31:0]};
  endfunction

  function automatic xlen_t sext_word(xlen_t v);
    return {{32{v[31]}}, v[31:0]};
  endfunction

  function automatic xlen_t rand64();
    return {$urandom, $urandom};
  endfunction

  // expected response straight from the RV64IM rules
  function automatic ex_rsp_t ref_rsp(ex_req_t r);
    xlen_t        a;
    xlen_t        b;
    xlen_t        da;
    xlen_t        db;
    xlen_t        raw;
    xlen_t        ext;
    logic [127:0] p;
    logic [5:0]   sh;
    logic         zero;
    logic         less;
    logic         taken;
    ex_rsp_t      rsp_exp;
    a = r.alu_a_pc ? r.pc : (r.word_cut ? zext_word(r.rs1) : r.rs1);
    case (r.alu_b_sel)
      B_SEL_RS2: b = r.word_cut ? zext_word(r.rs2) : r.rs2;
      B_SEL_IMM: b = r.word_cut ? zext_word(r.imm) : r.imm;
      default:   b = 64'd4;
    endcase
    sh = r.word_cut ? {1'b0, b[4:0]} : b[5:0];
    da = r.word_cut ? sext_word(a) : a;
    db = r.word_cut ? sext_word(b) : b;
    p = '0;
    case (r.alu_op)
      ALU_COPY_IMM: raw = r.imm;
      ALU_ADD:      raw = a + b;
      ALU_SUB:      raw = a - b;
      ALU_SLT:      raw = xlen_t'($signed(a) < $signed(b));
      ALU_SLTU:     raw = xlen_t'(a < b);
      ALU_XOR:      raw = a ^ b;
      ALU_AND:      raw = a & b;
      ALU_OR:       raw = a | b;
      ALU_SLL:      raw = a << sh;
      ALU_SRL:      raw = a >> sh;
      ALU_SRA:      raw = $signed(da) >>> sh;
      ALU_MUL: begin
        p = {64'h0, a} * {64'h0, b};
        raw = p[63:0];
      end
      ALU_MULH: begin
        p = {{64{a[63]}}, a} * {{64{b[63]}}, b};
        raw = p[127:64];
      end
      ALU_MULHSU: begin
        p = {{64{a[63]}}, a} * {64'h0, b};
        raw = p[127:64];
      end
      ALU_MULHU: begin
        p = {64'h0, a} * {64'h0, b};
        raw = p[127:64];
      end
      ALU_DIV: begin
        if (db == '0) raw = '1;
        else if (da == MOST_NEG && db == '1) raw = da;
        else raw = $signed(da) / $signed(db);
      end
      ALU_REM: begin
        if (db == '0) raw = da;
        else if (da == MOST_NEG && db == '1) raw = '0;
        else raw = $signed(da) % $signed(db);
      end
      ALU_DIVU: raw = (b == '0) ? '1 : a / b;
      ALU_REMU: raw = (b == '0) ? a : a % b;
      default:  raw = '0;
    endcase
    rsp_exp.alu_result = r.word_cut ? sext_word(raw) : raw;
    zero = (a == b);
    less = (r.alu_op == ALU_SLTU) ? (a < b) : ($signed(a) < $signed(b));
    case (r.branch)
      BR_JAL, BR_JALR: taken = 1'b1;
      BR_BEQ:          taken = zero;
      BR_BNE:          taken = !zero;
      BR_BLT:          taken = less;
      BR_BGE:          taken = !less;
      default:         taken = 1'b0;
    endcase
    rsp_exp.next_pc = ((r.branch == BR_JALR) ? r.rs1 : r.pc) + (taken ? r.imm : 64'd4);
    case (r.mem_op)
      MEM_LB:  ext = {{56{r.rdata[7]}}, r.rdata[7:0]};
      MEM_LBU: ext = {56'h0, r.rdata[7:0]};
      MEM_LH:  ext = {{48{r.rdata[15]}}, r.rdata[15:0]};
      MEM_LHU: ext = {48'h0, r.rdata[15:0]};
      MEM_LW:  ext = {{32{r.rdata[31]}}, r.rdata[31:0]};
      MEM_LWU: ext = {32'h0, r.rdata[31:0]};
      default: ext = r.rdata;
    endcase
    if (r.mem_to_reg) rsp_exp.gpr_wdata = ext;
    else if (r.sel_csr) rsp_exp.gpr_wdata = r.rs2;
    else rsp_exp.gpr_wdata = rsp_exp.alu_result;
    rsp_exp.csr_wdata = (r.ex_ctr == EX_CSR_WR) ? a : '0;
    return rsp_exp;
  endfunction

  function automatic ex_req_t alu_req(alu_op_e op, xlen_t a, xlen_t b, logic word);
    ex_req_t r;
    r = '0;
    r.rs1       = a;
    r.rs2       = b;
    r.alu_op    = op;
    r.alu_b_sel = B_SEL_RS2;
    r.word_cut  = word;
    r.branch    = BR_NONE;
    r.mem_op    = MEM_LD;
    r.ex_ctr    = EX_NONE;
    return r;
  endfunction

  function automatic ex_req_t rand_req();
    ex_req_t r;
    r = alu_req(op_list[$urandom_range(0, 18)], rand64(), rand64(), $urandom_range(0, 1) == 1);
    r.imm        = rand64();
    r.pc         = rand64();
    r.rdata      = rand64();
    r.alu_a_pc   = $urandom_range(0, 1) == 1;
    r.alu_b_sel  = alu_b_sel_e'($urandom_range(0, 2));
    r.branch     = br_list[$urandom_range(0, 6)];
    r.mem_op     = mem_op_e'($urandom_range(0, 6));
    r.mem_to_reg = $urandom_range(0, 1) == 1;
    r.sel_csr    = $urandom_range(0, 1) == 1;
    r.ex_ctr     = ($urandom_range(0, 1) == 1) ? EX_CSR_WR : EX_NONE;
    return r;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic compare_rsp(input ex_rsp_t exp, input string tag);
    check({tag, " o_rsp.alu_result"}, rsp.alu_result, exp.alu_result);
    check({tag, " o_rsp.next_pc"}, rsp.next_pc, exp.next_pc);
    check({tag, " o_rsp.gpr_wdata"}, rsp.gpr_wdata, exp.gpr_wdata);
    check({tag, " o_rsp.csr_wdata"}, rsp.csr_wdata, exp.csr_wdata);
  endtask

  // one strobe with its response sampled in the following cycle
  task automatic run_one(input ex_req_t r, input string tag);
    @(posedge clk);
    valid <= 1'b1;
    req   <= r;
    @(posedge clk);
    valid <= 1'b0;
    @(negedge clk);
    check({tag, " o_valid"}, rsp_valid, 1);
    compare_rsp(ref_rsp(r), tag);
  endtask

  task automatic pulse_reset();
    @(posedge clk);
    tb_rst_n <= 1'b0;
    repeat (2) @(posedge clk);
    tb_rst_n <= 1'b1;
    @(negedge clk);
  endtask

  task automatic alu_ops();
    ex_req_t r;
    run_one(alu_req(ALU_ADD, 64'h7fff_ffff_ffff_ffff, 64'h1, 1'b0), "add");
    run_one(alu_req(ALU_SUB, 64'h5, 64'h9, 1'b0), "sub");
    run_one(alu_req(ALU_SLT, 64'hffff_ffff_ffff_fffd, 64'h2, 1'b0), "slt");
    run_one(alu_req(ALU_SLTU, 64'hffff_ffff_ffff_fffd, 64'h2, 1'b0), "sltu");
    run_one(alu_req(ALU_XOR, 64'hf0f0_1234_5678_9abc, 64'h0ff0_ffff_0000_ffff, 1'b0), "xor");
    run_one(alu_req(ALU_AND, 64'hf0f0_1234_5678_9abc, 64'h0ff0_ffff_0000_ffff, 1'b0), "and");
    run_one(alu_req(ALU_OR, 64'hf0f0_1234_5678_9abc, 64'h0ff0_ffff_0000_ffff, 1'b0), "or");
    run_one(alu_req(ALU_SLL, 64'h8000_0000_0000_0001, 64'd68, 1'b0), "sll");
    run_one(alu_req(ALU_SRL, 64'h8000_0000_0000_0000, 64'd63, 1'b0), "srl");
    run_one(alu_req(ALU_SRA, 64'h8000_0000_0000_0000, 64'd60, 1'b0), "sra");
    // upper input bits must not leak into word forms
    run_one(alu_req(ALU_ADD, 64'hdead_0000_7fff_ffff, 64'h1, 1'b1), "addw");
    run_one(alu_req(ALU_SLL, 64'h1, 64'h3f, 1'b1), "sllw");
    run_one(alu_req(ALU_SRA, 64'hdead_beef_8000_0000, 64'h4, 1'b1), "sraw");
    run_one(alu_req(ALU_SRL, 64'hdead_beef_8000_0000, 64'h4, 1'b1), "srlw");
    r = alu_req(ALU_ADD, 64'h0, 64'h0, 1'b0);
    r.alu_a_pc  = 1'b1;
    r.pc        = 64'h8000_0000_0000_1000;
    r.alu_b_sel = B_SEL_FOUR;
    run_one(r, "pc plus 4");
    r = alu_req(ALU_ADD, 64'h1234, 64'h0, 1'b1);
    r.alu_b_sel = B_SEL_IMM;
    r.imm       = 64'hffff_ffff_ffff_fff0;
    run_one(r, "addiw");
    r = alu_req(ALU_COPY_IMM, 64'h5, 64'h6, 1'b0);
    r.imm = 64'hffff_ffff_abcd_e000;
    run_one(r, "copy imm");
    for (int i = 0; i < 20; i++) begin
      r = alu_req(op_list[$urandom_range(0, 9)], rand64(), rand64(), $urandom_range(0, 1) == 1);
      run_one(r, "random alu");
    end
  endtask

  task automatic mul_div();
    for (int i = 0; i < 16; i++) begin
      run_one(alu_req(op_list[10 + (i % 4)], rand64(), rand64(), 1'b0), "random mul");
    end
    run_one(alu_req(ALU_MULH, 64'hffff_ffff_ffff_fffe, 64'h3, 1'b0), "mulh negative");
    for (int i = 0; i < 4; i++) begin
      run_one(alu_req(op_list[14 + i], rand64(), 64'h0, 1'b0), "divide by zero");
    end
    run_one(alu_req(ALU_DIV, MOST_NEG, '1, 1'b0), "div overflow");
    run_one(alu_req(ALU_REM, MOST_NEG, '1, 1'b0), "rem overflow");
    run_one(alu_req(ALU_DIV, 64'hdead_beef_ffff_fff9, 64'h2, 1'b1), "divw");
    run_one(alu_req(ALU_REM, 64'hdead_beef_ffff_fff9, 64'h2, 1'b1), "remw");
    run_one(alu_req(ALU_DIV, 64'h1234_5678, 64'hffff_0000_0000_0000, 1'b1), "divw by zero");
    run_one(alu_req(ALU_DIV, 64'h8000_0000, 64'hffff_ffff, 1'b1), "divw overflow");
    for (int i = 0; i < 8; i++) begin
      run_one(alu_req(op_list[14 + (i % 4)], rand64(), rand64() >> 20, 1'b0), "random div");
    end
  endtask

  function automatic ex_req_t br_req(branch_e kind, alu_op_e op, xlen_t a, xlen_t b);
    ex_req_t r;
    r = alu_req(op, a, b, 1'b0);
    r.branch = kind;
    r.pc     = 64'h0000_0000_8000_0100;
    r.imm    = 64'hffff_ffff_ffff_ffe0;
    return r;
  endfunction

  task automatic next_pc_paths();
    run_one(br_req(BR_NONE, ALU_ADD, 64'h1, 64'h1), "no branch");
    run_one(br_req(BR_JAL, ALU_ADD, 64'h1, 64'h2), "jal");
    run_one(br_req(BR_JALR, ALU_ADD, 64'h2000, 64'h2), "jalr");
    run_one(br_req(BR_BEQ, ALU_SUB, 64'h5, 64'h5), "beq met");
    run_one(br_req(BR_BEQ, ALU_SUB, 64'h5, 64'h6), "beq not met");
    run_one(br_req(BR_BNE, ALU_SUB, 64'h5, 64'h6), "bne met");
    run_one(br_req(BR_BNE, ALU_SUB, 64'h5, 64'h5), "bne not met");
    run_one(br_req(BR_BLT, ALU_SLT, '1, 64'h1), "blt met");
    run_one(br_req(BR_BLT, ALU_SLT, 64'h1, '1), "blt not met");
    run_one(br_req(BR_BLT, ALU_SLTU, 64'h1, '1), "bltu met");
    run_one(br_req(BR_BLT, ALU_SLTU, '1, 64'h1), "bltu not met");
    run_one(br_req(BR_BGE, ALU_SLT, 64'h1, '1), "bge met");
    run_one(br_req(BR_BGE, ALU_SLT, '1, 64'h1), "bge not met");
    run_one(br_req(BR_BGE, ALU_SLTU, '1, 64'h1), "bgeu met");
    run_one(br_req(BR_BGE, ALU_SLTU, 64'h1, '1), "bgeu not met");
  endtask

  task automatic writeback_select();
    ex_req_t r;
    for (int pass = 0; pass < 2; pass++) begin
      r = alu_req(ALU_ADD, rand64(), rand64(), 1'b0);
      r.rdata      = (pass == 0) ? 64'hfedc_ba98_8765_c3a1 : rand64();
      r.mem_to_reg = 1'b1;
      for (int k = 0; k < 7; k++) begin
        r.mem_op = mem_op_e'(k);
        run_one(r, "load extend");
      end
      r.mem_to_reg = 1'b0;
      r.sel_csr    = 1'b1;
      run_one(r, "csr read to rs2");
      r.sel_csr = 1'b0;
      run_one(r, "alu result");
    end
  endtask

  task automatic status_flags();
    ex_req_t r;
    ex_req_t idle_req;
    check("o_halt before ebreak", halt, 0);
    check("o_abort before invalid", abort, 0);
    r = alu_req(ALU_ADD, rand64(), rand64(), 1'b0);
    r.ex_ctr = EX_CSR_WR;
    run_one(r, "csr write");
    r.alu_a_pc = 1'b1;
    r.pc       = 64'h0000_0000_8000_4000;
    run_one(r, "csr write from pc");
    r.ex_ctr = EX_NONE;
    run_one(r, "no csr write");
    r.ex_ctr = EX_EBREAK;
    run_one(r, "ebreak");
    check("o_halt", halt, 1);
    check("o_abort", abort, 0);
    // a changed invalid request without strobe is not taken
    idle_req              = r;
    idle_req.rs2          = ~r.rs2;
    idle_req.invalid_inst = 1'b1;
    @(posedge clk);
    req <= idle_req;
    repeat (3) @(negedge clk);
    check("o_valid idle", rsp_valid, 0);
    check("o_halt held", halt, 1);
    check("o_abort without strobe", abort, 0);
    compare_rsp(ref_rsp(r), "held");
    r.ex_ctr       = EX_NONE;
    r.invalid_inst = 1'b1;
    run_one(r, "invalid");
    check("o_abort", abort, 1);
    r.invalid_inst = 1'b0;
    run_one(r, "after invalid");
    check("o_halt sticky", halt, 1);
    check("o_abort sticky", abort, 1);
    pulse_reset();
    check("o_halt after reset", halt, 0);
    check("o_abort after reset", abort, 0);
    check("o_valid after reset", rsp_valid, 0);
    compare_rsp('0, "after reset");
  endtask

  // o_valid must follow each strobe by exactly one cycle
  task automatic back_to_back();
    ex_rsp_t exp_q [$];
    ex_req_t r;
    int      sent;
    logic    strobe;
    logic    strobe_prev;
    sent        = 0;
    strobe_prev = 1'b0;
    while (sent < 50 || exp_q.size() > 0) begin
      @(posedge clk);
      strobe = (sent < 50) && ($urandom_range(0, 3) != 0);
      if (strobe) begin
        r = rand_req();
        valid <= 1'b1;
        req   <= r;
        exp_q.push_back(ref_rsp(r));
        sent++;
      end else begin
        valid <= 1'b0;
      end
      @(negedge clk);
      check("stream o_valid", rsp_valid, strobe_prev);
      if (rsp_valid) begin
        compare_rsp(exp_q.pop_front(), "stream");
      end
      strobe_prev = strobe;
    end
  endtask

  initial begin
    seed     = $urandom(17330);
    valid    = 1'b0;
    req      = '0;
    tb_rst_n = 1'b1;
    wait (gen_rst_n === 1'b1);
    @(negedge clk);
    check("o_valid after power-on", rsp_valid, 0);
    check("o_halt after power-on", halt, 0);
    check("o_abort after power-on", abort, 0);
    compare_rsp('0, "power-on");
    alu_ops();
    mul_div();
    next_pc_paths();
    writeback_select();
    status_flags();
    back_to_back();
    repeat (2) @(posedge clk);
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
exu_pkg.sv
exu_bus_pkg.sv
key_mux.sv
exu_alu.sv
exu_branch.sv
exu_wb_sel.sv
exu_core.sv
exu_top.sv
tb_clk_gen.sv
exu_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing -Wno-fatal -f all.f --top-module exu_tb -o exu_sim \
  && ./obj_dir/exu_sim | tee /dev/stderr | grep -q "PASS: all tests" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
